//--- cam_cfg_pkg.sv
/*
 * CAM geometry and array traffic types.
 * Import into any block that carries CAM requests or match vectors.
 */
`default_nettype none

package cam_cfg_pkg;

   // --------------------------------------
   // Array geometry
   // --------------------------------------

   // Bits per entry
   localparam int CAM_WIDTH = 16;
   // Number of entries
   localparam int CAM_DEPTH = 8;
   // Entry address width
   localparam int CAM_AW    = 3;
   // Bit index width, wide enough for CAM_WIDTH positions
   localparam int CAM_BW    = 4;

   // --------------------------------------
   // Meaningful vector types
   // --------------------------------------

   typedef logic [CAM_WIDTH-1:0] cam_data_t;
   typedef logic [CAM_AW-1:0]    cam_addr_t;
   typedef logic [CAM_DEPTH-1:0] cam_match_t;
   typedef logic [CAM_BW-1:0]    cam_bit_t;

   // Last entry and last bit position, used as sweep end points
   localparam cam_addr_t CAM_LAST_ADDR = cam_addr_t'(CAM_DEPTH - 1);
   localparam cam_bit_t  CAM_LAST_BIT  = cam_bit_t'(CAM_WIDTH - 1);

   // One cycle of array traffic, write port and compare port side by side
   typedef struct packed {
      logic      wr_en;
      cam_addr_t wr_addr;
      cam_data_t wr_data;
      logic      cm_en;
      cam_data_t cm_data;
   } cam_req_t;

endpackage : cam_cfg_pkg

`default_nettype wire

//--- bist_pkg.sv
/*
 * Self-test sequencer types and constants.
 * Shared by the BIST controller, the input handler and the top level.
 */
`default_nettype none

package bist_pkg;
   import cam_cfg_pkg::*;

   // --------------------------------------
   // Sequencer
   // --------------------------------------

   // Write, match and mask phases, then one drain cycle for the last compare
   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      MATCH,
      MASK,
      DRAIN,
      DONE
   } bist_state_e;

   // Controls from the sequencer toward the input handler
   typedef struct packed {
      logic cm_mode;
      logic rotate_mask;
      logic cd_mask_en;
      logic data_inv;
   } bist_ctrl_t;

   // Mismatch counter, saturates at all ones
   localparam int FAIL_W = 8;
   typedef logic [FAIL_W-1:0] fail_cnt_t;
   localparam fail_cnt_t FAIL_MAX = '1;

   // Background word before the per-address scramble
   localparam cam_data_t BIST_BG_PATTERN = 16'hA5C0;

endpackage : bist_pkg

`default_nettype wire

//--- cam_bist_inhandler.sv
/*
 * CAM input handler. Holds the rotating compare mask, applies data
 * inversion and mask to BIST traffic and selects BIST or functional
 * requests toward the array.
 */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_inhandler
   import cam_cfg_pkg::*;
   import bist_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  bist_ctrl_t bist_ctrl,
   input  cam_req_t   bist_req,
   input  cam_req_t   func_req,
   output cam_req_t   array_req
);

   // One-hot mask, a single position flipped in the compare word
   cam_data_t mask_q;
   // Data inversion spread across the word
   cam_data_t inv_word;
   // Mask as applied, zero when masking is off
   cam_data_t cd_mask;
   // BIST request after inversion and masking
   cam_req_t  bist_mod;

   // --------------------------------------
   // Rotating mask register
   // --------------------------------------

   // Starts at bit 0, steps left, top bit wraps back to bit 0
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask_q <= cam_data_t'(1);
      end else if (bist_ctrl.rotate_mask) begin
         mask_q <= {mask_q[CAM_WIDTH-2:0], mask_q[CAM_WIDTH-1]};
      end
   end

   // --------------------------------------
   // Write and compare data generation
   // --------------------------------------

   assign inv_word = {CAM_WIDTH{bist_ctrl.data_inv}};
   assign cd_mask  = bist_ctrl.cd_mask_en ? mask_q : '0;

   always_comb begin
      // Enables and address pass straight through
      bist_mod         = bist_req;
      // Inverted background for writes
      bist_mod.wr_data = bist_req.wr_data ^ inv_word;
      // Same inversion on compares, plus one flipped bit in the mask phase
      bist_mod.cm_data = bist_req.cm_data ^ inv_word ^ cd_mask;
   end

   // BIST owns the array while cm_mode is set
   assign array_req = bist_ctrl.cm_mode ? bist_mod : func_req;

   // --------------------------------------
   // Checks
   // --------------------------------------

   // Rotation must never lose or duplicate the marker bit
   a_mask_onehot : assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      $onehot(mask_q)
   );

endmodule : cam_bist_inhandler

`default_nettype wire

//--- cam_array.sv
/*
 * Behavioural binary CAM. One write port, one compare port and a
 * match vector registered one cycle after the compare.
 */
`timescale 1ns/1ps
`default_nettype none

module cam_array
   import cam_cfg_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  cam_req_t   array_req,
   output cam_match_t match
);

   // Entry storage
   cam_data_t  mem_q [CAM_DEPTH];
   // Entry holds a written word
   cam_match_t valid_q;
   // Raw hits for the current compare
   cam_match_t hit;

   // --------------------------------------
   // Write port
   // --------------------------------------

   // Entry words are gated by their valid bits on compare
   always_ff @(posedge bist_clk) begin
      if (array_req.wr_en) begin
         mem_q[array_req.wr_addr] <= array_req.wr_data;
      end
   end

   // --------------------------------------
   // Compare port
   // --------------------------------------

   // A compare sees the old contents when a write lands at the same edge
   always_comb begin
      for (int i = 0; i < CAM_DEPTH; i++) begin
         hit[i] = valid_q[i] && (mem_q[i] == array_req.cm_data);
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         valid_q <= '0;
         match   <= '0;
      end else begin
         if (array_req.wr_en) begin
            valid_q[array_req.wr_addr] <= 1'b1;
         end
         // Idle cycles read back as no hit
         match <= array_req.cm_en ? hit : '0;
      end
   end

   // Writes stay inside the array
   a_wr_addr_range : assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      array_req.wr_en |-> (int'(array_req.wr_addr) < CAM_DEPTH)
   );

endmodule : cam_array

`default_nettype wire

//--- cam_bist_ctrl.sv
/*
 * BIST sequencer. Writes a background to every entry, checks each entry
 * for a single hit, then walks one flipped bit through every position
 * and expects no hit. Mismatches are counted and reported at done.
 */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_ctrl
   import cam_cfg_pkg::*;
   import bist_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       bist_start,
   input  logic       bist_data_inv,
   input  cam_match_t match,
   output cam_req_t   bist_req,
   output bist_ctrl_t bist_ctrl,
   output logic       bist_busy,
   output logic       bist_done,
   output logic       bist_pass,
   output fail_cnt_t  fail_count
);

   bist_state_e state_q;
   cam_addr_t   addr_q;
   cam_bit_t    bit_q;
   // Inversion latched at start and held for the whole run
   logic        inv_q;
   // Start accepted in this cycle
   logic        start_ok;
   // Background word for the current address
   cam_data_t   bg_word;
   // Expected match vector trailing the compare by one cycle
   cam_match_t  exp_d;
   cam_match_t  exp_q;
   logic        exp_vld_d;
   logic        exp_vld_q;
   logic        miss;
   fail_cnt_t   fail_next;

   // Per-address scramble keeps any two entries five bits apart
   function automatic cam_data_t scramble(input cam_addr_t a);
      return BIST_BG_PATTERN ^ cam_data_t'({a[0], {5{a}}});
   endfunction

   // --------------------------------------
   // Sequencing
   // --------------------------------------

   // Done is not busy, so a new run may start straight from it
   assign start_ok = bist_start && ((state_q == IDLE) || (state_q == DONE));

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state_q <= IDLE;
         addr_q  <= '0;
         bit_q   <= '0;
         inv_q   <= 1'b0;
      end else if (start_ok) begin
         state_q <= WRITE;
         addr_q  <= '0;
         bit_q   <= '0;
         inv_q   <= bist_data_inv;
      end else begin
         case (state_q)
            WRITE: begin
               addr_q <= (addr_q == CAM_LAST_ADDR) ? '0 : addr_q + 1'b1;
               if (addr_q == CAM_LAST_ADDR) begin
                  state_q <= MATCH;
               end
            end
            MATCH: begin
               addr_q <= (addr_q == CAM_LAST_ADDR) ? '0 : addr_q + 1'b1;
               if (addr_q == CAM_LAST_ADDR) begin
                  state_q <= MASK;
               end
            end
            MASK: begin
               // Bit counter runs inside the address loop
               if (bit_q == CAM_LAST_BIT) begin
                  bit_q  <= '0;
                  addr_q <= (addr_q == CAM_LAST_ADDR) ? '0 : addr_q + 1'b1;
                  if (addr_q == CAM_LAST_ADDR) begin
                     state_q <= DRAIN;
                  end
               end else begin
                  bit_q <= bit_q + 1'b1;
               end
            end
            // Last compare result arrives here
            DRAIN:   state_q <= DONE;
            DONE:    state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // --------------------------------------
   // Request and handler controls
   // --------------------------------------

   assign bg_word = scramble(addr_q);

   always_comb begin
      bist_req = '0;
      case (state_q)
         WRITE: begin
            bist_req.wr_en   = 1'b1;
            bist_req.wr_addr = addr_q;
            bist_req.wr_data = bg_word;
         end
         MATCH, MASK: begin
            // Handler adds the flipped bit in the mask phase
            bist_req.cm_en   = 1'b1;
            bist_req.cm_data = bg_word;
         end
         default: ;
      endcase
   end

   assign bist_ctrl.cm_mode     = state_q inside {WRITE, MATCH, MASK, DRAIN};
   assign bist_ctrl.rotate_mask = (state_q == MASK);
   assign bist_ctrl.cd_mask_en  = (state_q == MASK);
   assign bist_ctrl.data_inv    = inv_q;

   assign bist_busy = (state_q != IDLE) && (state_q != DONE);
   assign bist_done = (state_q == DONE);

   // --------------------------------------
   // Prediction and checking
   // --------------------------------------

   // Match phase expects its own entry and mask phase expects no hit
   always_comb begin
      exp_d     = '0;
      exp_vld_d = 1'b0;
      if (state_q == MATCH) begin
         exp_d     = cam_match_t'(1) << addr_q;
         exp_vld_d = 1'b1;
      end else if (state_q == MASK) begin
         exp_vld_d = 1'b1;
      end
   end

   // Expected vector lines up with the registered match
   always_ff @(posedge bist_clk) begin
      exp_q <= exp_d;
   end

   assign miss      = exp_vld_q && (match != exp_q);
   assign fail_next = (miss && (fail_count != FAIL_MAX)) ? fail_count + 1'b1 : fail_count;

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         exp_vld_q  <= 1'b0;
         fail_count <= '0;
         bist_pass  <= 1'b0;
      end else begin
         exp_vld_q <= exp_vld_d;
         if (start_ok) begin
            fail_count <= '0;
            bist_pass  <= 1'b0;
         end else begin
            fail_count <= fail_next;
            // Verdict includes the final check of the drain cycle
            if (state_q == DRAIN) begin
               bist_pass <= (fail_next == '0);
            end
         end
      end
   end

   // --------------------------------------
   // Checks
   // --------------------------------------

   a_done_not_busy : assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      bist_done |-> !bist_busy
   );

   // Array ownership follows the busy window exactly
   a_cm_mode_busy : assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      bist_ctrl.cm_mode == bist_busy
   );

endmodule : cam_bist_ctrl

`default_nettype wire

//--- cam_bist_top.sv
/*
 * CAM with self-test. Connects the BIST sequencer, the input handler
 * and the array. Functional traffic reaches the array while BIST idles.
 */
`timescale 1ns/1ps
`default_nettype none

module cam_bist_top
   import cam_cfg_pkg::*;
   import bist_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  cam_req_t   func_req,
   input  logic       bist_start,
   input  logic       bist_data_inv,
   output cam_match_t match,
   output logic       bist_busy,
   output logic       bist_done,
   output logic       bist_pass,
   output fail_cnt_t  fail_count
);

   // Sequencer to handler
   cam_req_t   bist_req;
   bist_ctrl_t bist_ctrl;
   // Handler to array
   cam_req_t   array_req;

   // --------------------------------------
   // Sequencer
   // --------------------------------------

   cam_bist_ctrl i_ctrl (
      .bist_clk      (bist_clk),
      .rst_b         (rst_b),
      .bist_start    (bist_start),
      .bist_data_inv (bist_data_inv),
      .match         (match),
      .bist_req      (bist_req),
      .bist_ctrl     (bist_ctrl),
      .bist_busy     (bist_busy),
      .bist_done     (bist_done),
      .bist_pass     (bist_pass),
      .fail_count    (fail_count)
   );

   // --------------------------------------
   // Request select and array
   // --------------------------------------

   cam_bist_inhandler i_inhandler (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .bist_ctrl (bist_ctrl),
      .bist_req  (bist_req),
      .func_req  (func_req),
      .array_req (array_req)
   );

   // Match goes out and back to the sequencer
   cam_array i_array (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .array_req (array_req),
      .match     (match)
   );

endmodule : cam_bist_top

`default_nettype wire

//--- tb_cam_bist_top.sv
/*
 * Testbench for the CAM with self-test. Runs the command list from
 * cam_bist_vectors.txt: functional writes and compares, and BIST runs
 * with or without inversion and with a functional write held while busy.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bist_top
   import cam_cfg_pkg::*;
   import bist_pkg::*;
();

   // Half of the 20 ns clock period
   localparam int CLK_HALF     = 10;
   // Inputs change this long after the rising edge
   localparam int DRIVE_DLY    = 2;
   localparam int RESET_CYCLES = 5;
   // Upper bound for one BIST run, in cycles
   localparam int DONE_TIMEOUT = 400;
   localparam int VEC_DEPTH    = 64;

   // Command word: op, addr, inv, data, match, pass, fail_count
   typedef logic [47:0] vec_t;

   logic       bist_clk;
   logic       rst_b;
   cam_req_t   func_req;
   logic       bist_start;
   logic       bist_data_inv;
   cam_match_t match;
   logic       bist_busy;
   logic       bist_done;
   logic       bist_pass;
   fail_cnt_t  fail_count;

   vec_t vectors [VEC_DEPTH];
   int   error_count;

   cam_bist_top i_dut (
      .bist_clk      (bist_clk),
      .rst_b         (rst_b),
      .func_req      (func_req),
      .bist_start    (bist_start),
      .bist_data_inv (bist_data_inv),
      .match         (match),
      .bist_busy     (bist_busy),
      .bist_done     (bist_done),
      .bist_pass     (bist_pass),
      .fail_count    (fail_count)
   );

   initial begin
      bist_clk = 1'b0;
      forever #CLK_HALF bist_clk = ~bist_clk;
   end

   // --------------------------------------
   // Helpers
   // --------------------------------------

   // Step to the drive point of the next cycle
   task automatic next_cycle();
      @(posedge bist_clk);
      #DRIVE_DLY;
   endtask

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         error_count++;
         stop_on_error($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // One write cycle through the functional port
   task automatic func_write(input cam_addr_t addr, input cam_data_t data);
      func_req.wr_en   = 1'b1;
      func_req.wr_addr = addr;
      func_req.wr_data = data;
      next_cycle();
      func_req = '0;
   endtask

   // Match is registered, so it is read one cycle after the compare
   task automatic func_compare(input cam_data_t data, input cam_match_t exp);
      func_req.cm_en   = 1'b1;
      func_req.cm_data = data;
      next_cycle();
      func_req = '0;
      check_value("match", match, exp);
   endtask

   // Start pulse, optional functional write held while busy, then done
   task automatic bist_run(input logic inv, input logic busy_wr, input cam_addr_t addr,
                           input cam_data_t data, input logic exp_pass,
                           input fail_cnt_t exp_fail);
      int   cycles;
      logic seen;
      cycles        = 0;
      seen          = 1'b0;
      bist_start    = 1'b1;
      bist_data_inv = inv;
      next_cycle();
      bist_start = 1'b0;
      check_value("bist_busy", bist_busy, 1);
      if (busy_wr) begin
         func_req.wr_en   = 1'b1;
         func_req.wr_addr = addr;
         func_req.wr_data = data;
      end
      while (!seen && cycles < DONE_TIMEOUT) begin
         next_cycle();
         cycles++;
         seen = (bist_done === 1'b1);
      end
      // Dropped before the edge that ends the done cycle
      func_req = '0;
      if (!seen) begin
         stop_on_error("timeout while waiting for bist_done after bist_start");
      end
      check_value("bist_busy", bist_busy, 0);
      check_value("bist_pass", bist_pass, exp_pass);
      check_value("fail_count", fail_count, exp_fail);
   endtask

   // --------------------------------------
   // Command sequence
   // --------------------------------------

   initial begin
      int   idx;
      logic finished;
      vec_t cmd;
      idx           = 0;
      finished      = 1'b0;
      error_count   = 0;
      rst_b         = 1'b0;
      func_req      = '0;
      bist_start    = 1'b0;
      bist_data_inv = 1'b0;
      // Unloaded slots stay unknown and hit the default branch
      for (int i = 0; i < VEC_DEPTH; i++) begin
         vectors[i] = 'x;
      end
      $readmemh("cam_bist_vectors.txt", vectors);

      repeat (RESET_CYCLES) @(posedge bist_clk);
      #DRIVE_DLY;
      rst_b = 1'b1;
      check_value("bist_busy", bist_busy, 0);
      check_value("bist_done", bist_done, 0);
      check_value("bist_pass", bist_pass, 0);
      check_value("match", match, 0);

      while (!finished && idx < VEC_DEPTH) begin
         cmd = vectors[idx];
         case (cmd[47:44])
            4'h0: func_write(cam_addr_t'(cmd[43:40]), cmd[35:20]);
            4'h1: func_compare(cmd[35:20], cmd[19:12]);
            4'h2: bist_run(cmd[36], 1'b0, '0, '0, cmd[8], cmd[7:0]);
            // Same run with a functional write during busy
            4'h3: bist_run(cmd[36], 1'b1, cam_addr_t'(cmd[43:40]), cmd[35:20],
                           cmd[8], cmd[7:0]);
            4'hF: finished = 1'b1;
            default: stop_on_error($sformatf("unknown command in vector line %0d", idx));
         endcase
         idx++;
      end
      if (!finished) begin
         stop_on_error("vector table ended without an end command");
      end

      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule : tb_cam_bist_top

`default_nettype wire

//--- cam_bist_vectors.txt
// Columns, 12 hex digits: O A I DDDD MM P FF
// O op (0 wr, 1 cmp, 2 bist, 3 bist + busy wr, F end), A addr, I inv, D data, M match, P pass, F fails
100000000000
000111100000
010222200000
020111100000
050BEEF00000
100111105000
100222202000
100BEEF20000
100333300000
200000000100
200000000100
100A5C001000
100378902000
100815204000
100131B08000
100ECE410000
1007EAD20000
100C87640000
1005A3F80000
330000000100
100131B08000
100000000000
201000000100
1005A3F01000
1007EAD04000
100131B10000
100A5C080000
// Inverted background mirrors the address, so the plain word of entry 2 hits entry 5
100815220000
1005A3E00000
F00000000000

//--- src.f
cam_cfg_pkg.sv
bist_pkg.sv
cam_bist_inhandler.sv
cam_array.sv
cam_bist_ctrl.sv
cam_bist_top.sv
tb_cam_bist_top.sv

//--- Bender.yml
package:
  name: cam_bist

sources:
  - files:
      - cam_cfg_pkg.sv
      - bist_pkg.sv
      - cam_bist_inhandler.sv
      - cam_array.sv
      - cam_bist_ctrl.sv
      - cam_bist_top.sv
  - target: test
    files:
      - tb_cam_bist_top.sv
